// File: verilog/core_pkg.sv
`default_nettype none

package core_pkg;

  localparam int ADDR_W = 32;
  localparam int INSTR_W = 32;
  localparam int DATA_W = 64;
  // line as the core sees it, in 64-bit words
  localparam int LINE_WORDS = 4;

  typedef struct packed {
    logic [ADDR_W-1:0] pc;
    logic [INSTR_W-1:0] instr;
  } fetch_out_t;

  typedef struct packed {
    logic taken;
    logic [ADDR_W-1:0] target;
  } redirect_t;

  typedef struct packed {
    logic store;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } data_req_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
  } lookup_req_t;

  // words[0] holds the lowest address of the line
  typedef struct packed {
    logic [LINE_WORDS-1:0][DATA_W-1:0] words;
  } lookup_resp_t;

endpackage

`default_nettype wire

// File: verilog/mem_pkg.sv
`default_nettype none

package mem_pkg;

  localparam int BUS_DATA_W = 64;
  localparam int BUS_TAG_W = 13;
  localparam int LINE_BYTES = 32;
  localparam int LINE_W = LINE_BYTES * 8;
  localparam int BEATS_PER_LINE = LINE_W / BUS_DATA_W;
  localparam int BEAT_W = $clog2(BEATS_PER_LINE);
  localparam int CACHE_LINES = 8;
  localparam int INDEX_W = $clog2(CACHE_LINES);
  localparam int OFFSET_W = $clog2(LINE_BYTES);
  localparam int LINE_ADDR_W = core_pkg::ADDR_W - OFFSET_W;
  localparam int TAG_W = core_pkg::ADDR_W - INDEX_W - OFFSET_W;

  // top bit selects read, bits 11:8 select the memory device
  localparam logic [BUS_TAG_W-1:0] TAG_READ = 13'h1100;
  localparam logic [BUS_TAG_W-1:0] TAG_WRITE = 13'h0100;

  typedef logic [LINE_W-1:0] line_t;

  typedef struct packed {
    logic [LINE_ADDR_W-1:0] addr;
    logic write;
    line_t data;
  } line_req_t;

  typedef struct packed {
    logic valid;
    logic [LINE_ADDR_W-1:0] addr;
    line_t data;
  } line_update_t;

endpackage

`default_nettype wire

// File: verilog/fetch_unit.sv
`default_nettype none
`timescale 1ns/100ps

module fetch_unit (
  input logic clk,
  input logic reset,
  input logic [core_pkg::ADDR_W-1:0] entry,
  output logic fetch_req,
  output core_pkg::fetch_out_t fetch_out,
  input logic fetch_ack,
  input core_pkg::redirect_t redirect,
  output logic lookup_req,
  output core_pkg::lookup_req_t lookup_addr,
  input logic lookup_ack,
  input core_pkg::lookup_resp_t lookup_line
);

  typedef enum logic [1:0] {IDLE, LOOKUP, PRESENT} state_t;

  state_t state;
  logic [core_pkg::ADDR_W-1:0] pc;
  logic [core_pkg::INSTR_W-1:0] instr;
  logic [core_pkg::DATA_W-1:0] word;

  assign word = lookup_line.words[pc[mem_pkg::OFFSET_W-1:3]];

  assign lookup_req = (state == LOOKUP);
  assign lookup_addr.addr = pc;
  assign fetch_req = (state == PRESENT);
  assign fetch_out.pc = pc;
  assign fetch_out.instr = instr;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      pc <= entry;
    end else begin
      case (state)
        IDLE: begin
          // both handshakes of the last fetch have to be back to low
          if (!fetch_ack && !lookup_ack) begin
            state <= LOOKUP;
          end
        end
        LOOKUP: begin
          if (lookup_ack) begin
            state <= PRESENT;
          end
        end
        PRESENT: begin
          if (fetch_ack) begin
            state <= IDLE;
            pc <= redirect.taken ? redirect.target : pc + 32'd4;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // pc bit 2 picks the half of the 64-bit word
  always_ff @(posedge clk) begin
    if (state == LOOKUP && lookup_ack) begin
      instr <= word[pc[2]*core_pkg::INSTR_W +: core_pkg::INSTR_W];
    end
  end

endmodule

`default_nettype wire

// File: verilog/line_cache.sv
`default_nettype none
`timescale 1ns/100ps

module line_cache (
  input logic clk,
  input logic reset,
  input logic lookup_req,
  input core_pkg::lookup_req_t lookup_addr,
  output logic lookup_ack,
  output core_pkg::lookup_resp_t lookup_line,
  output logic fill_req,
  output mem_pkg::line_req_t fill,
  input logic fill_ack,
  input mem_pkg::line_t fill_line,
  input mem_pkg::line_update_t update
);

  typedef enum logic [1:0] {IDLE, FILL, ACK} state_t;

  state_t state;
  logic valid [mem_pkg::CACHE_LINES];
  logic [mem_pkg::TAG_W-1:0] tags [mem_pkg::CACHE_LINES];
  mem_pkg::line_t lines [mem_pkg::CACHE_LINES];
  mem_pkg::line_t resp;
  logic [mem_pkg::INDEX_W-1:0] index;
  logic [mem_pkg::INDEX_W-1:0] upd_index;
  logic [mem_pkg::TAG_W-1:0] tag;
  logic [mem_pkg::TAG_W-1:0] upd_tag;
  logic hit;
  logic upd_hit;

  assign index = lookup_addr.addr[mem_pkg::OFFSET_W +: mem_pkg::INDEX_W];
  assign tag = lookup_addr.addr[core_pkg::ADDR_W-1 -: mem_pkg::TAG_W];
  assign hit = valid[index] && (tags[index] == tag);

  // update carries a line address, no offset bits
  assign upd_index = update.addr[mem_pkg::INDEX_W-1:0];
  assign upd_tag = update.addr[mem_pkg::LINE_ADDR_W-1 -: mem_pkg::TAG_W];
  assign upd_hit = update.valid && valid[upd_index] && (tags[upd_index] == upd_tag);

  assign lookup_ack = (state == ACK);
  assign lookup_line = resp;
  assign fill_req = (state == FILL);
  assign fill.addr = lookup_addr.addr[core_pkg::ADDR_W-1:mem_pkg::OFFSET_W];
  assign fill.write = 1'b0;
  assign fill.data = '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      for (int i = 0; i < mem_pkg::CACHE_LINES; i++) begin
        valid[i] <= 1'b0;
        tags[i] <= '0;
        lines[i] <= '0;
      end
    end else begin
      case (state)
        IDLE: begin
          if (lookup_req && hit) begin
            resp <= lines[index];
            state <= ACK;
          end else if (lookup_req && !fill_ack) begin
            state <= FILL;
          end
        end
        FILL: begin
          if (fill_ack) begin
            valid[index] <= 1'b1;
            tags[index] <= tag;
            lines[index] <= fill_line;
            resp <= fill_line;
            state <= ACK;
          end
        end
        ACK: begin
          if (!lookup_req) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
      // only resident lines follow a write, others are not allocated
      if (upd_hit) begin
        lines[upd_index] <= update.data;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/load_store_unit.sv
`default_nettype none
`timescale 1ns/100ps

module load_store_unit (
  input logic clk,
  input logic reset,
  input logic data_req,
  input core_pkg::data_req_t data_in,
  output logic data_ack,
  output logic [core_pkg::DATA_W-1:0] load_data,
  output logic lookup_req,
  output core_pkg::lookup_req_t lookup_addr,
  input logic lookup_ack,
  input core_pkg::lookup_resp_t lookup_line,
  output logic wr_req,
  output mem_pkg::line_req_t wr_line,
  input logic wr_ack
);

  typedef enum logic [1:0] {IDLE, LOOKUP, WRITE, ACK} state_t;

  state_t state;
  logic [mem_pkg::OFFSET_W-4:0] word_sel;
  core_pkg::lookup_resp_t merged;
  mem_pkg::line_t wr_data;
  logic [core_pkg::DATA_W-1:0] result;

  assign word_sel = data_in.addr[mem_pkg::OFFSET_W-1:3];

  // store word dropped into the line read from the dcache
  always_comb begin
    merged = lookup_line;
    merged.words[word_sel] = data_in.wdata;
  end

  assign lookup_req = (state == LOOKUP);
  assign lookup_addr.addr = data_in.addr;
  assign wr_req = (state == WRITE);
  assign wr_line.addr = data_in.addr[core_pkg::ADDR_W-1:mem_pkg::OFFSET_W];
  assign wr_line.write = 1'b1;
  assign wr_line.data = wr_data;
  assign data_ack = (state == ACK);
  assign load_data = result;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (data_req && !lookup_ack && !wr_ack) begin
            state <= LOOKUP;
          end
        end
        LOOKUP: begin
          if (lookup_ack) begin
            state <= data_in.store ? WRITE : ACK;
          end
        end
        WRITE: begin
          // write finished, dcache already has the update
          if (wr_ack) begin
            state <= ACK;
          end
        end
        ACK: begin
          if (!data_req) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == LOOKUP && lookup_ack) begin
      wr_data <= merged;
      result <= data_in.store ? '0 : lookup_line.words[word_sel];
    end
  end

endmodule

`default_nettype wire

// File: verilog/line_arbiter.sv
`default_nettype none
`timescale 1ns/100ps

module line_arbiter (
  input logic clk,
  input logic reset,
  input logic wr_req,
  input mem_pkg::line_req_t wr_job,
  output logic wr_ack,
  input logic dfill_req,
  input mem_pkg::line_req_t dfill_job,
  output logic dfill_ack,
  input logic ifill_req,
  input mem_pkg::line_req_t ifill_job,
  output logic ifill_ack,
  output mem_pkg::line_t fill_line,
  output logic mem_req,
  output mem_pkg::line_req_t mem_job,
  input logic mem_ack,
  input mem_pkg::line_t mem_line,
  output mem_pkg::line_update_t update
);

  typedef enum logic [1:0] {IDLE, BUSY, DONE} state_t;
  typedef enum logic [1:0] {G_WR, G_DFILL, G_IFILL} grant_t;

  state_t state;
  grant_t grant;
  logic granted_req;
  logic upd_valid;
  mem_pkg::line_t line_r;

  // granted client's payload stays stable until its req drops
  always_comb begin
    case (grant)
      G_WR: begin
        mem_job = wr_job;
        granted_req = wr_req;
      end
      G_DFILL: begin
        mem_job = dfill_job;
        granted_req = dfill_req;
      end
      default: begin
        mem_job = ifill_job;
        granted_req = ifill_req;
      end
    endcase
  end

  assign mem_req = (state == BUSY);
  assign wr_ack = (state == DONE) && (grant == G_WR);
  assign dfill_ack = (state == DONE) && (grant == G_DFILL);
  assign ifill_ack = (state == DONE) && (grant == G_IFILL);
  assign fill_line = line_r;
  assign update.valid = upd_valid;
  assign update.addr = mem_job.addr;
  assign update.data = mem_job.data;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      grant <= G_WR;
      upd_valid <= 1'b0;
    end else begin
      upd_valid <= 1'b0;
      case (state)
        IDLE: begin
          if (!mem_ack) begin
            if (wr_req) begin
              grant <= G_WR;
              state <= BUSY;
            end else if (dfill_req) begin
              grant <= G_DFILL;
              state <= BUSY;
            end else if (ifill_req) begin
              grant <= G_IFILL;
              state <= BUSY;
            end
          end
        end
        BUSY: begin
          if (mem_ack) begin
            upd_valid <= mem_job.write;
            state <= DONE;
          end
        end
        DONE: begin
          if (!granted_req) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == BUSY && mem_ack) begin
      line_r <= mem_line;
    end
  end

endmodule

`default_nettype wire

// File: verilog/bus_controller.sv
`default_nettype none
`timescale 1ns/100ps

module bus_controller (
  input logic clk,
  input logic reset,
  input logic mem_req,
  input mem_pkg::line_req_t mem_job,
  output logic mem_ack,
  output mem_pkg::line_t mem_line,
  output logic bus_reqcyc,
  output logic bus_respack,
  output logic [mem_pkg::BUS_DATA_W-1:0] bus_req,
  output logic [mem_pkg::BUS_TAG_W-1:0] bus_reqtag,
  input logic bus_respcyc,
  input logic bus_reqack,
  input logic [mem_pkg::BUS_DATA_W-1:0] bus_resp,
  input logic [mem_pkg::BUS_TAG_W-1:0] bus_resptag
);

  typedef enum logic [2:0] {IDLE, ADDR, WDATA, RDATA, ACK} state_t;

  state_t state;
  logic [mem_pkg::BEAT_W-1:0] beat;
  logic [mem_pkg::BEATS_PER_LINE-1:0][mem_pkg::BUS_DATA_W-1:0] rd_beats;
  logic [mem_pkg::BEATS_PER_LINE-1:0][mem_pkg::BUS_DATA_W-1:0] wr_beats;
  logic last;
  logic resp_hit;

  assign wr_beats = mem_job.data;
  assign last = (beat == mem_pkg::BEATS_PER_LINE - 1);
  // responses for other tags belong to someone else
  assign resp_hit = bus_respcyc && (bus_resptag == mem_pkg::TAG_READ);

  assign bus_reqcyc = (state == ADDR) || (state == WDATA);
  assign bus_respack = (state == RDATA) && resp_hit;
  assign bus_reqtag = mem_job.write ? mem_pkg::TAG_WRITE : mem_pkg::TAG_READ;
  assign mem_ack = (state == ACK);
  assign mem_line = rd_beats;

  always_comb begin
    bus_req = '0;
    if (state == WDATA) begin
      bus_req = wr_beats[beat];
    end else begin
      bus_req[core_pkg::ADDR_W-1:0] = {mem_job.addr, {mem_pkg::OFFSET_W{1'b0}}};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      beat <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (mem_req) begin
            state <= ADDR;
          end
        end
        ADDR: begin
          if (bus_reqack) begin
            beat <= '0;
            state <= mem_job.write ? WDATA : RDATA;
          end
        end
        WDATA: begin
          // low word of the line goes out first
          if (bus_reqack) begin
            beat <= beat + 1'b1;
            if (last) begin
              state <= ACK;
            end
          end
        end
        RDATA: begin
          if (resp_hit) begin
            beat <= beat + 1'b1;
            if (last) begin
              state <= ACK;
            end
          end
        end
        ACK: begin
          if (!mem_req) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == RDATA && resp_hit) begin
      rd_beats[beat] <= bus_resp;
    end
  end

endmodule

`default_nettype wire

// File: verilog/core_memory_top.sv
`default_nettype none
`timescale 1ns/100ps

module core_memory_top (
  input logic clk,
  input logic reset,
  input logic [core_pkg::ADDR_W-1:0] entry,
  output logic fetch_req,
  output core_pkg::fetch_out_t fetch_out,
  input logic fetch_ack,
  input core_pkg::redirect_t redirect,
  input logic data_req,
  input core_pkg::data_req_t data_in,
  output logic data_ack,
  output logic [core_pkg::DATA_W-1:0] load_data,
  output logic bus_reqcyc,
  output logic bus_respack,
  output logic [mem_pkg::BUS_DATA_W-1:0] bus_req,
  output logic [mem_pkg::BUS_TAG_W-1:0] bus_reqtag,
  input logic bus_respcyc,
  input logic bus_reqack,
  input logic [mem_pkg::BUS_DATA_W-1:0] bus_resp,
  input logic [mem_pkg::BUS_TAG_W-1:0] bus_resptag
);

  logic ilookup_req;
  logic ilookup_ack;
  logic dlookup_req;
  logic dlookup_ack;
  core_pkg::lookup_req_t ilookup_addr;
  core_pkg::lookup_req_t dlookup_addr;
  core_pkg::lookup_resp_t ilookup_line;
  core_pkg::lookup_resp_t dlookup_line;
  logic ifill_req;
  logic ifill_ack;
  logic dfill_req;
  logic dfill_ack;
  logic wr_req;
  logic wr_ack;
  logic mem_req;
  logic mem_ack;
  mem_pkg::line_req_t ifill_job;
  mem_pkg::line_req_t dfill_job;
  mem_pkg::line_req_t wr_job;
  mem_pkg::line_req_t mem_job;
  mem_pkg::line_t fill_line;
  mem_pkg::line_t mem_line;
  mem_pkg::line_update_t update;

  fetch_unit fetch_unit_i (
    .clk, .reset, .entry,
    .fetch_req, .fetch_out, .fetch_ack, .redirect,
    .lookup_req(ilookup_req), .lookup_addr(ilookup_addr),
    .lookup_ack(ilookup_ack), .lookup_line(ilookup_line)
  );

  line_cache icache (
    .clk, .reset,
    .lookup_req(ilookup_req), .lookup_addr(ilookup_addr),
    .lookup_ack(ilookup_ack), .lookup_line(ilookup_line),
    .fill_req(ifill_req), .fill(ifill_job), .fill_ack(ifill_ack),
    .fill_line, .update
  );

  line_cache dcache (
    .clk, .reset,
    .lookup_req(dlookup_req), .lookup_addr(dlookup_addr),
    .lookup_ack(dlookup_ack), .lookup_line(dlookup_line),
    .fill_req(dfill_req), .fill(dfill_job), .fill_ack(dfill_ack),
    .fill_line, .update
  );

  load_store_unit load_store_unit_i (
    .clk, .reset,
    .data_req, .data_in, .data_ack, .load_data,
    .lookup_req(dlookup_req), .lookup_addr(dlookup_addr),
    .lookup_ack(dlookup_ack), .lookup_line(dlookup_line),
    .wr_req, .wr_line(wr_job), .wr_ack
  );

  line_arbiter line_arbiter_i (
    .clk, .reset,
    .wr_req, .wr_job, .wr_ack,
    .dfill_req, .dfill_job, .dfill_ack,
    .ifill_req, .ifill_job, .ifill_ack,
    .fill_line,
    .mem_req, .mem_job, .mem_ack, .mem_line,
    .update
  );

  bus_controller bus_controller_i (
    .clk, .reset,
    .mem_req, .mem_job, .mem_ack, .mem_line,
    .bus_reqcyc, .bus_respack, .bus_req, .bus_reqtag,
    .bus_respcyc, .bus_reqack, .bus_resp, .bus_resptag
  );

endmodule

`default_nettype wire

// File: verification/tb_clock.sv
`default_nettype none
`timescale 1ns/100ps

module tb_clock (
  output logic clk,
  output logic reset
);

  localparam int HALF_PERIOD = 50;
  localparam int RESET_CYCLES = 8;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // released shortly after an edge, like the other inputs
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #10;
    reset = 1'b0;
  end

endmodule

`default_nettype wire

// File: verification/bus_memory_model.sv
`default_nettype none
`timescale 1ns/100ps

module bus_memory_model (
  input logic clk,
  input logic bus_reqcyc,
  input logic bus_respack,
  input logic [mem_pkg::BUS_DATA_W-1:0] bus_req,
  input logic [mem_pkg::BUS_TAG_W-1:0] bus_reqtag,
  output logic bus_respcyc,
  output logic bus_reqack,
  output logic [mem_pkg::BUS_DATA_W-1:0] bus_resp,
  output logic [mem_pkg::BUS_TAG_W-1:0] bus_resptag
);

  // written 64-bit words indexed by byte address / 8
  logic [63:0] words [int];
  integer seed;
  int read_count;
  int tag_errors;

  // untouched words hold a xor 32'hc0de_0000 with the low word at the lower address
  function automatic logic [63:0] read_word(input logic [31:0] addr);
    logic [31:0] base;
    base = {addr[31:3], 3'b000};
    if (words.exists(int'(base >> 3))) begin
      return words[int'(base >> 3)];
    end
    return {(base + 32'd4) ^ 32'hc0de_0000, base ^ 32'hc0de_0000};
  endfunction

  task automatic tick();
    @(posedge clk);
    #10;
  endtask

  task automatic serve_request();
    logic [31:0] base;
    logic write;
    int gap;
    gap = 2 + ({$random(seed)} % 4);
    repeat (gap - 1) tick();
    base = bus_req[31:0];
    write = (bus_reqtag == mem_pkg::TAG_WRITE);
    if (!write && bus_reqtag !== mem_pkg::TAG_READ) begin
      $display("[FAIL] bus_reqtag expected 0x%h got 0x%h", mem_pkg::TAG_READ, bus_reqtag);
      tag_errors++;
    end
    bus_reqack = 1'b1;
    tick();
    if (write) begin
      // ack stays high and one data beat is taken per cycle
      for (int i = 0; i < mem_pkg::BEATS_PER_LINE; i++) begin
        words[int'(base >> 3) + i] = bus_req;
        tick();
      end
      bus_reqack = 1'b0;
    end else begin
      bus_reqack = 1'b0;
      read_count++;
      repeat (gap) tick();
      for (int i = 0; i < mem_pkg::BEATS_PER_LINE; i++) begin
        bus_respcyc = 1'b1;
        bus_resptag = mem_pkg::TAG_READ;
        bus_resp = read_word(base + 32'(8 * i));
        #1;
        while (bus_respack !== 1'b1) begin
          tick();
        end
        tick();
      end
      bus_respcyc = 1'b0;
      bus_resp = '0;
    end
  endtask

  initial begin
    seed = 32'he0b4_6c9f;
    read_count = 0;
    tag_errors = 0;
    bus_respcyc = 1'b0;
    bus_reqack = 1'b0;
    bus_resp = '0;
    bus_resptag = '0;
    forever begin
      tick();
      if (bus_reqcyc === 1'b1) begin
        serve_request();
      end
    end
  end

endmodule

`default_nettype wire

// File: verification/core_memory_tb.sv
`default_nettype none
`timescale 1ns/100ps

module core_memory_tb;

  localparam logic [31:0] ENTRY = 32'h0000_1000;
  localparam int HANDSHAKE_LIMIT = 200;
  // well above the few hundred cycles the tests take
  localparam int WATCHDOG_CYCLES = 20000;

  logic clk;
  logic reset;
  logic [core_pkg::ADDR_W-1:0] entry;
  logic fetch_req;
  core_pkg::fetch_out_t fetch_out;
  logic fetch_ack;
  core_pkg::redirect_t redirect;
  logic data_req;
  core_pkg::data_req_t data_in;
  logic data_ack;
  logic [core_pkg::DATA_W-1:0] load_data;
  logic bus_reqcyc;
  logic bus_respack;
  logic [mem_pkg::BUS_DATA_W-1:0] bus_req;
  logic [mem_pkg::BUS_TAG_W-1:0] bus_reqtag;
  logic bus_respcyc;
  logic bus_reqack;
  logic [mem_pkg::BUS_DATA_W-1:0] bus_resp;
  logic [mem_pkg::BUS_TAG_W-1:0] bus_resptag;

  int value_errors;
  int handshake_errors;
  // stored words indexed by byte address / 8
  logic [63:0] shadow [int];

  tb_clock clock_i (.clk, .reset);

  bus_memory_model memory_i (
    .clk, .bus_reqcyc, .bus_respack, .bus_req, .bus_reqtag,
    .bus_respcyc, .bus_reqack, .bus_resp, .bus_resptag
  );

  core_memory_top core_memory_top_i (
    .clk, .reset, .entry,
    .fetch_req, .fetch_out, .fetch_ack, .redirect,
    .data_req, .data_in, .data_ack, .load_data,
    .bus_reqcyc, .bus_respack, .bus_req, .bus_reqtag,
    .bus_respcyc, .bus_reqack, .bus_resp, .bus_resptag
  );

  function automatic logic [31:0] rule_word(input logic [31:0] addr);
    return addr ^ 32'hc0de_0000;
  endfunction

  function automatic logic [63:0] expected_dword(input logic [31:0] addr);
    logic [31:0] base;
    base = {addr[31:3], 3'b000};
    if (shadow.exists(int'(base >> 3))) begin
      return shadow[int'(base >> 3)];
    end
    return {rule_word(base + 32'd4), rule_word(base)};
  endfunction

  function automatic logic [31:0] expected_instr(input logic [31:0] addr);
    logic [63:0] dword;
    dword = expected_dword(addr);
    return addr[2] ? dword[63:32] : dword[31:0];
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #10;
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
    $display("[FAIL] %s expected 0x%h got 0x%h", name, expected, actual);
    value_errors++;
  endtask

  task automatic wait_fetch_req(input logic level);
    int n;
    n = 0;
    while (fetch_req !== level && n < HANDSHAKE_LIMIT) begin
      next_cycle();
      n++;
    end
    if (fetch_req !== level) begin
      $display("fetch_req did not go to %b within %0d cycles", level, HANDSHAKE_LIMIT);
      handshake_errors++;
    end
  endtask

  task automatic wait_data_ack(input logic level);
    int n;
    n = 0;
    while (data_ack !== level && n < HANDSHAKE_LIMIT) begin
      next_cycle();
      n++;
    end
    if (data_ack !== level) begin
      $display("data_ack did not go to %b within %0d cycles", level, HANDSHAKE_LIMIT);
      handshake_errors++;
    end
  endtask

  // redirect is sampled with the first fetch_ack
  task automatic accept_fetch(input logic taken, input logic [31:0] target);
    fetch_ack = 1'b1;
    redirect.taken = taken;
    redirect.target = target;
    wait_fetch_req(1'b0);
    fetch_ack = 1'b0;
    redirect = '0;
  endtask

  task automatic data_access(input logic store, input logic [31:0] addr,
                             input logic [63:0] wdata, output logic [63:0] rdata);
    data_in.store = store;
    data_in.addr = addr;
    data_in.wdata = wdata;
    data_req = 1'b1;
    wait_data_ack(1'b1);
    rdata = load_data;
    data_req = 1'b0;
    wait_data_ack(1'b0);
  endtask

  task automatic first_fetch_after_reset();
    wait (reset === 1'b0);
    next_cycle();
    if (fetch_req !== 1'b0) report_mismatch("fetch_req", 64'h0, 64'(fetch_req));
    if (data_ack !== 1'b0) report_mismatch("data_ack", 64'h0, 64'(data_ack));
    if (bus_reqcyc !== 1'b0) report_mismatch("bus_reqcyc", 64'h0, 64'(bus_reqcyc));
    if (bus_respack !== 1'b0) report_mismatch("bus_respack", 64'h0, 64'(bus_respack));
    wait_fetch_req(1'b1);
    if (fetch_out.pc !== ENTRY) report_mismatch("fetch_out.pc", 64'(ENTRY), 64'(fetch_out.pc));
    if (fetch_out.instr !== expected_instr(ENTRY)) begin
      report_mismatch("fetch_out.instr", 64'(expected_instr(ENTRY)), 64'(fetch_out.instr));
    end
  endtask

  // ten fetches cover two lines
  task automatic sequential_fetch();
    logic [31:0] pc;
    pc = ENTRY;
    for (int i = 0; i < 10; i++) begin
      wait_fetch_req(1'b1);
      if (fetch_out.pc !== pc) report_mismatch("fetch_out.pc", 64'(pc), 64'(fetch_out.pc));
      if (fetch_out.instr !== expected_instr(pc)) begin
        report_mismatch("fetch_out.instr", 64'(expected_instr(pc)), 64'(fetch_out.instr));
      end
      accept_fetch(1'b0, '0);
      pc = pc + 32'd4;
    end
    wait_fetch_req(1'b1);
    if (fetch_out.pc !== pc) report_mismatch("fetch_out.pc", 64'(pc), 64'(fetch_out.pc));
    if (memory_i.read_count != 2) begin
      report_mismatch("bus read count", 64'd2, 64'(memory_i.read_count));
    end
  endtask

  task automatic redirected_fetch();
    logic [31:0] target;
    int reads;
    target = 32'h0000_2044;
    reads = memory_i.read_count;
    wait_fetch_req(1'b1);
    accept_fetch(1'b1, target);
    wait_fetch_req(1'b1);
    if (fetch_out.pc !== target) begin
      report_mismatch("fetch_out.pc", 64'(target), 64'(fetch_out.pc));
    end
    if (fetch_out.instr !== expected_instr(target)) begin
      report_mismatch("fetch_out.instr", 64'(expected_instr(target)), 64'(fetch_out.instr));
    end
    if (memory_i.read_count != reads + 1) begin
      report_mismatch("bus read count", 64'(reads + 1), 64'(memory_i.read_count));
    end
  endtask

  // second load of the line must hit in the dcache
  task automatic repeated_load();
    logic [31:0] addr;
    logic [63:0] rdata;
    int reads;
    addr = 32'h0000_3010;
    reads = memory_i.read_count;
    data_access(1'b0, addr, '0, rdata);
    if (rdata !== expected_dword(addr)) report_mismatch("load_data", expected_dword(addr), rdata);
    if (memory_i.read_count != reads + 1) begin
      report_mismatch("bus read count", 64'(reads + 1), 64'(memory_i.read_count));
    end
    data_access(1'b0, addr, '0, rdata);
    if (rdata !== expected_dword(addr)) report_mismatch("load_data", expected_dword(addr), rdata);
    if (memory_i.read_count != reads + 1) begin
      report_mismatch("bus read count", 64'(reads + 1), 64'(memory_i.read_count));
    end
  endtask

  task automatic store_then_load();
    logic [31:0] addr;
    logic [31:0] neighbour;
    logic [63:0] wdata;
    logic [63:0] rdata;
    addr = 32'h0000_3018;
    neighbour = 32'h0000_3010;
    wdata = 64'h1122_3344_5566_7788;
    data_access(1'b1, addr, wdata, rdata);
    if (rdata !== 64'h0) report_mismatch("load_data", 64'h0, rdata);
    shadow[int'(addr >> 3)] = wdata;
    data_access(1'b0, addr, '0, rdata);
    if (rdata !== expected_dword(addr)) report_mismatch("load_data", expected_dword(addr), rdata);
    data_access(1'b0, neighbour, '0, rdata);
    if (rdata !== expected_dword(neighbour)) begin
      report_mismatch("load_data", expected_dword(neighbour), rdata);
    end
    // line write has to reach the memory too
    if (memory_i.read_word(addr) !== expected_dword(addr)) begin
      report_mismatch("memory word", expected_dword(addr), memory_i.read_word(addr));
    end
  endtask

  // icache holds line 0x1000 from the first fetches
  task automatic store_then_fetch();
    logic [31:0] addr;
    logic [63:0] wdata;
    logic [63:0] rdata;
    int reads;
    addr = 32'h0000_1008;
    wdata = 64'hdead_beef_0bad_f00d;
    data_access(1'b1, addr, wdata, rdata);
    if (rdata !== 64'h0) report_mismatch("load_data", 64'h0, rdata);
    shadow[int'(addr >> 3)] = wdata;
    reads = memory_i.read_count;
    wait_fetch_req(1'b1);
    accept_fetch(1'b1, addr);
    wait_fetch_req(1'b1);
    if (fetch_out.pc !== addr) report_mismatch("fetch_out.pc", 64'(addr), 64'(fetch_out.pc));
    if (fetch_out.instr !== expected_instr(addr)) begin
      report_mismatch("fetch_out.instr", 64'(expected_instr(addr)), 64'(fetch_out.instr));
    end
    if (memory_i.read_count != reads) begin
      report_mismatch("bus read count", 64'(reads), 64'(memory_i.read_count));
    end
  endtask

  initial begin
    value_errors = 0;
    handshake_errors = 0;
    entry = ENTRY;
    fetch_ack = 1'b0;
    redirect = '0;
    data_req = 1'b0;
    data_in = '0;
    first_fetch_after_reset();
    sequential_fetch();
    redirected_fetch();
    repeated_load();
    store_then_load();
    store_then_fetch();
    $display("value errors: %0d, handshake errors: %0d, bus tag errors: %0d",
             value_errors, handshake_errors, memory_i.tag_errors);
    if (value_errors == 0 && handshake_errors == 0 && memory_i.tag_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("value errors: %0d, handshake errors: %0d, bus tag errors: %0d",
             value_errors, handshake_errors, memory_i.tag_errors);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
verilog/core_pkg.sv
verilog/mem_pkg.sv
verilog/fetch_unit.sv
verilog/line_cache.sv
verilog/load_store_unit.sv
verilog/line_arbiter.sv
verilog/bus_controller.sv
verilog/core_memory_top.sv
verification/tb_clock.sv
verification/bus_memory_model.sv
verification/core_memory_tb.sv
